//--- build.f
+incdir+tests
logic/chip8_pkg.sv
logic/chip8_alu.sv
logic/chip8_pc_stack.sv
logic/chip8_regfile.sv
logic/chip8_store_engine.sv
logic/chip8_sequencer.sv
logic/chip8_cpu.sv
tests/chip8_tb.sv

//--- logic/chip8_alu.sv
`timescale 1ns/1ps

module chip8_alu (
  input  logic                     clk_in,
  input  logic                     arst_n_i,
  input  logic                     start_i,
  input  chip8_pkg::chip8_alu_op_e op_i,
  input  chip8_pkg::chip8_byte_t   a_i,
  input  chip8_pkg::chip8_byte_t   b_i,
  input  chip8_pkg::chip8_addr_t   index_i,
  output chip8_pkg::chip8_addr_t   result_o,
  output logic                     flag_o,
  output logic                     zero_o,
  output logic                     done_o
);

  import chip8_pkg::*;

  logic [CHIP8_DATA_W:0] sum;
  chip8_byte_t           res_b;
  chip8_addr_t           res_w;
  logic                  flag_c;

  assign sum = {1'b0, a_i} + {1'b0, b_i};

  always_comb begin
    res_b  = '0;
    flag_c = 1'b0;  // logic ops clear it
    case (op_i)
      ALU_PASS: res_b = b_i;
      ALU_ADD: begin
        res_b  = sum[CHIP8_DATA_W-1:0];
        flag_c = sum[CHIP8_DATA_W];  // carry
      end
      ALU_OR:  res_b = a_i | b_i;
      ALU_AND: res_b = a_i & b_i;
      ALU_XOR: res_b = a_i ^ b_i;
      ALU_SUB: begin
        res_b  = a_i - b_i;
        flag_c = (a_i >= b_i);  // no borrow
      end
      ALU_SHR: begin
        res_b  = {1'b0, a_i[CHIP8_DATA_W-1:1]};
        flag_c = a_i[0];
      end
      ALU_SHL: begin
        res_b  = {a_i[CHIP8_DATA_W-2:0], 1'b0};
        flag_c = a_i[CHIP8_DATA_W-1];
      end
      default: ;
    endcase
  end

  assign res_w = (op_i == ALU_ADD_INDEX) ? index_i + chip8_addr_t'(a_i) : chip8_addr_t'(res_b);

  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) done_o <= 1'b0;
    else done_o <= start_i;
  end

  always_ff @(posedge clk_in) begin
    if (start_i) begin
      result_o <= res_w;
      flag_o   <= flag_c;
      zero_o   <= ~|(a_i ^ b_i);  // equality for skips
    end
  end

endmodule

//--- logic/chip8_cpu.sv
`timescale 1ns/1ps

module chip8_cpu (
  input  logic                   clk_in,
  input  logic                   arst_n_i,
  input  chip8_pkg::chip8_byte_t rd_data_i,
  output chip8_pkg::chip8_addr_t rd_addr_o,
  output chip8_pkg::chip8_addr_t wr_addr_o,
  output chip8_pkg::chip8_byte_t wr_data_o,
  output logic                   wr_en_o,
  output logic                   halt_o
);

  import chip8_pkg::*;

  chip8_addr_t       pc;
  chip8_pc_cmd_e     pc_cmd;
  chip8_addr_t       pc_target;
  chip8_reg_idx_t    rx_idx;
  chip8_reg_idx_t    ry_idx;
  chip8_reg_idx_t    rs_idx;
  chip8_byte_t       vx;
  chip8_byte_t       vy;
  chip8_byte_t       vs;
  chip8_addr_t       i_reg;
  logic              reg_we;
  chip8_reg_idx_t    reg_widx;
  chip8_byte_t       reg_wdata;
  logic              flag_we;
  logic              flag;
  logic              i_we;
  chip8_addr_t       i_wdata;
  logic              alu_start;
  chip8_alu_op_e     alu_op;
  chip8_byte_t       alu_a;
  chip8_byte_t       alu_b;
  chip8_addr_t       alu_result;
  logic              alu_flag;
  logic              alu_zero;
  logic              alu_done;
  logic              st_start;
  chip8_store_kind_e st_kind;
  logic              st_done;

  chip8_sequencer u_sequencer (
    .clk_in(clk_in), .arst_n_i(arst_n_i),
    .rd_data_i(rd_data_i), .rd_addr_o(rd_addr_o),
    .pc_i(pc), .pc_cmd_o(pc_cmd), .pc_target_o(pc_target),
    .rx_idx_o(rx_idx), .ry_idx_o(ry_idx), .vx_i(vx), .vy_i(vy), .i_reg_i(i_reg),
    .reg_we_o(reg_we), .reg_widx_o(reg_widx), .reg_wdata_o(reg_wdata),
    .flag_we_o(flag_we), .flag_o(flag), .i_we_o(i_we), .i_wdata_o(i_wdata),
    .alu_start_o(alu_start), .alu_op_o(alu_op), .alu_a_o(alu_a), .alu_b_o(alu_b),
    .alu_result_i(alu_result), .alu_flag_i(alu_flag), .alu_zero_i(alu_zero),
    .alu_done_i(alu_done), .st_start_o(st_start), .st_kind_o(st_kind),
    .st_done_i(st_done), .halt_o(halt_o)
  );

  chip8_pc_stack u_pc_stack (
    .clk_in(clk_in), .arst_n_i(arst_n_i),
    .cmd_i(pc_cmd), .target_i(pc_target), .pc_o(pc)
  );

  chip8_regfile u_regfile (
    .clk_in(clk_in), .arst_n_i(arst_n_i),
    .rx_idx_i(rx_idx), .ry_idx_i(ry_idx), .rs_idx_i(rs_idx),
    .vx_o(vx), .vy_o(vy), .vs_o(vs),
    .we_i(reg_we), .widx_i(reg_widx), .wdata_i(reg_wdata),
    .flag_we_i(flag_we), .flag_i(flag),
    .i_we_i(i_we), .i_wdata_i(i_wdata), .i_reg_o(i_reg)
  );

  chip8_alu u_alu (
    .clk_in(clk_in), .arst_n_i(arst_n_i),
    .start_i(alu_start), .op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .index_i(i_reg),
    .result_o(alu_result), .flag_o(alu_flag), .zero_o(alu_zero), .done_o(alu_done)
  );

  // x of the opcode names both the last register and the bcd source
  chip8_store_engine u_store_engine (
    .clk_in(clk_in), .arst_n_i(arst_n_i),
    .start_i(st_start), .kind_i(st_kind), .last_idx_i(rx_idx), .base_i(i_reg),
    .rs_idx_o(rs_idx), .vs_i(vs),
    .wr_addr_o(wr_addr_o), .wr_data_o(wr_data_o), .wr_en_o(wr_en_o), .done_o(st_done)
  );

endmodule

//--- logic/chip8_pc_stack.sv
`timescale 1ns/1ps

module chip8_pc_stack (
  input  logic                     clk_in,
  input  logic                     arst_n_i,
  input  chip8_pkg::chip8_pc_cmd_e cmd_i,
  input  chip8_pkg::chip8_addr_t   target_i,
  output chip8_pkg::chip8_addr_t   pc_o
);

  import chip8_pkg::*;

  chip8_addr_t                          stack_mem [CHIP8_STACK_DEPTH];
  logic [$clog2(CHIP8_STACK_DEPTH)-1:0] sp;
  logic [$clog2(CHIP8_STACK_DEPTH)-1:0] sp_dec;

  assign sp_dec = sp - 1'b1;  // top of stack

  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_o <= CHIP8_PROG_START;
      sp   <= '0;
    end else begin
      case (cmd_i)
        PC_STEP: pc_o <= pc_o + chip8_addr_t'(2);
        PC_SKIP: pc_o <= pc_o + chip8_addr_t'(4);
        PC_JUMP: pc_o <= target_i;
        PC_CALL: begin
          sp   <= sp + 1'b1;  // wraps past depth
          pc_o <= target_i;
        end
        PC_RET: begin
          sp   <= sp_dec;
          pc_o <= stack_mem[sp_dec] + chip8_addr_t'(2);  // back past the call
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (cmd_i == PC_CALL) stack_mem[sp] <= pc_o;
  end

endmodule

//--- logic/chip8_pkg.sv
package chip8_pkg;

  localparam int CHIP8_ADDR_W      = 12;
  localparam int CHIP8_DATA_W      = 8;
  localparam int CHIP8_NUM_REGS    = 16;
  localparam int CHIP8_STACK_DEPTH = 16;
  localparam int CHIP8_FLAG_REG    = 15;

  typedef logic [CHIP8_ADDR_W-1:0] chip8_addr_t;
  typedef logic [CHIP8_DATA_W-1:0] chip8_byte_t;
  typedef logic [3:0]              chip8_reg_idx_t;

  localparam chip8_addr_t CHIP8_PROG_START = 12'h200;

  typedef enum logic [3:0] {
    ALU_PASS,
    ALU_ADD,
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_SUB,       // a minus b
    ALU_SHR,
    ALU_SHL,
    ALU_ADD_INDEX  // I plus a with 12 bit wrap
  } chip8_alu_op_e;

  typedef enum logic [2:0] {
    PC_HOLD,
    PC_STEP,
    PC_SKIP,
    PC_JUMP,
    PC_CALL,
    PC_RET
  } chip8_pc_cmd_e;

  typedef enum logic {
    STORE_BCD,
    STORE_REGS
  } chip8_store_kind_e;

  typedef enum logic [2:0] {
    SEQ_FETCH_HI,
    SEQ_FETCH_LO,
    SEQ_FETCH_WAIT,
    SEQ_DECODE,
    SEQ_EXEC,
    SEQ_WAIT_ALU,
    SEQ_WAIT_STORE,
    SEQ_HALT
  } chip8_seq_state_e;

  // one opcode word read three ways
  typedef union packed {
    struct packed {
      logic [3:0]     op;
      chip8_reg_idx_t x;
      chip8_reg_idx_t y;
      logic [3:0]     n;
    } xyn;
    struct packed {
      logic [3:0]     op;
      chip8_reg_idx_t x;
      chip8_byte_t    kk;
    } xkk;
    struct packed {
      logic [3:0]  op;
      chip8_addr_t addr;
    } nnn;
  } chip8_opcode_u;

endpackage

//--- logic/chip8_regfile.sv
`timescale 1ns/1ps

module chip8_regfile (
  input  logic                      clk_in,
  input  logic                      arst_n_i,
  input  chip8_pkg::chip8_reg_idx_t rx_idx_i,
  input  chip8_pkg::chip8_reg_idx_t ry_idx_i,
  input  chip8_pkg::chip8_reg_idx_t rs_idx_i,
  output chip8_pkg::chip8_byte_t    vx_o,
  output chip8_pkg::chip8_byte_t    vy_o,
  output chip8_pkg::chip8_byte_t    vs_o,
  input  logic                      we_i,
  input  chip8_pkg::chip8_reg_idx_t widx_i,
  input  chip8_pkg::chip8_byte_t    wdata_i,
  input  logic                      flag_we_i,
  input  logic                      flag_i,
  input  logic                      i_we_i,
  input  chip8_pkg::chip8_addr_t    i_wdata_i,
  output chip8_pkg::chip8_addr_t    i_reg_o
);

  import chip8_pkg::*;

  chip8_byte_t v_q [CHIP8_NUM_REGS];
  chip8_addr_t i_q;

  assign vx_o    = v_q[rx_idx_i];
  assign vy_o    = v_q[ry_idx_i];
  assign vs_o    = v_q[rs_idx_i];  // store engine port
  assign i_reg_o = i_q;

  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int k = 0; k < CHIP8_NUM_REGS; k++) begin
        v_q[k] <= '0;
      end
      i_q <= '0;
    end else begin
      if (we_i) v_q[widx_i] <= wdata_i;
      // later write wins when the result also targets VF
      if (flag_we_i) v_q[CHIP8_FLAG_REG] <= chip8_byte_t'(flag_i);
      if (i_we_i) i_q <= i_wdata_i;
    end
  end

endmodule

//--- logic/chip8_sequencer.sv
`timescale 1ns/1ps

module chip8_sequencer (
  input  logic                         clk_in,
  input  logic                         arst_n_i,
  input  chip8_pkg::chip8_byte_t       rd_data_i,
  output chip8_pkg::chip8_addr_t       rd_addr_o,
  input  chip8_pkg::chip8_addr_t       pc_i,
  output chip8_pkg::chip8_pc_cmd_e     pc_cmd_o,
  output chip8_pkg::chip8_addr_t       pc_target_o,
  output chip8_pkg::chip8_reg_idx_t    rx_idx_o,
  output chip8_pkg::chip8_reg_idx_t    ry_idx_o,
  input  chip8_pkg::chip8_byte_t       vx_i,
  input  chip8_pkg::chip8_byte_t       vy_i,
  input  chip8_pkg::chip8_addr_t       i_reg_i,
  output logic                         reg_we_o,
  output chip8_pkg::chip8_reg_idx_t    reg_widx_o,
  output chip8_pkg::chip8_byte_t       reg_wdata_o,
  output logic                         flag_we_o,
  output logic                         flag_o,
  output logic                         i_we_o,
  output chip8_pkg::chip8_addr_t       i_wdata_o,
  output logic                         alu_start_o,
  output chip8_pkg::chip8_alu_op_e     alu_op_o,
  output chip8_pkg::chip8_byte_t       alu_a_o,
  output chip8_pkg::chip8_byte_t       alu_b_o,
  input  chip8_pkg::chip8_addr_t       alu_result_i,
  input  logic                         alu_flag_i,
  input  logic                         alu_zero_i,
  input  logic                         alu_done_i,
  output logic                         st_start_o,
  output chip8_pkg::chip8_store_kind_e st_kind_o,
  input  logic                         st_done_i,
  output logic                         halt_o
);

  import chip8_pkg::*;

  chip8_seq_state_e  state;
  chip8_opcode_u     op_q;
  chip8_opcode_u     op_w;
  chip8_alu_op_e     alu_op_q;
  chip8_byte_t       alu_a_q;
  chip8_byte_t       alu_b_q;
  chip8_pc_cmd_e     pc_cmd_q;
  chip8_store_kind_e kind_q;
  logic              use_alu_q;
  logic              use_st_q;
  logic              skip_q;
  logic              ne_q;    // skip when operands differ
  logic              flag_q;
  logic              to_i_q;  // result goes to I

  assign op_w = {op_q.xkk.op, op_q.xkk.x, rd_data_i};  // low byte lands in decode

  assign rx_idx_o    = op_q.xyn.x;
  assign ry_idx_o    = op_w.xyn.y;
  assign pc_target_o = op_q.nnn.addr;
  assign reg_widx_o  = op_q.xyn.x;
  assign reg_wdata_o = alu_result_i[CHIP8_DATA_W-1:0];
  assign flag_o      = alu_flag_i;
  assign alu_op_o    = alu_op_q;
  assign alu_a_o     = alu_a_q;
  assign alu_b_o     = alu_b_q;
  assign st_kind_o   = kind_q;
  assign halt_o      = (state == SEQ_HALT);

  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state     <= SEQ_FETCH_HI;
      rd_addr_o <= CHIP8_PROG_START;
      op_q      <= '0;
      alu_op_q  <= ALU_PASS;
      alu_a_q   <= '0;
      alu_b_q   <= '0;
      pc_cmd_q  <= PC_HOLD;
      kind_q    <= STORE_BCD;
      use_alu_q <= 1'b0;
      use_st_q  <= 1'b0;
      skip_q    <= 1'b0;
      ne_q      <= 1'b0;
      flag_q    <= 1'b0;
      to_i_q    <= 1'b0;
    end else begin
      case (state)
        SEQ_FETCH_HI: begin
          rd_addr_o <= pc_i;
          state     <= SEQ_FETCH_LO;
        end
        SEQ_FETCH_LO: begin
          rd_addr_o <= pc_i + 1'b1;
          state     <= SEQ_FETCH_WAIT;
        end
        SEQ_FETCH_WAIT: begin
          op_q[15:8] <= rd_data_i;  // high byte
          state      <= SEQ_DECODE;
        end
        SEQ_DECODE: begin
          op_q      <= op_w;
          alu_op_q  <= ALU_PASS;
          alu_a_q   <= vx_i;
          alu_b_q   <= vy_i;
          pc_cmd_q  <= PC_STEP;
          kind_q    <= STORE_BCD;
          use_alu_q <= 1'b1;
          use_st_q  <= 1'b0;
          skip_q    <= 1'b0;
          ne_q      <= 1'b0;
          flag_q    <= 1'b0;
          to_i_q    <= 1'b0;
          state     <= SEQ_EXEC;
          case (op_w.xyn.op)
            4'h0: begin
              use_alu_q <= 1'b0;
              pc_cmd_q  <= PC_RET;
              if (op_w.nnn.addr != 12'h0EE) state <= SEQ_HALT;
            end
            4'h1, 4'h2: begin
              use_alu_q <= 1'b0;
              pc_cmd_q  <= op_w.xyn.op[1] ? PC_CALL : PC_JUMP;
            end
            4'h3, 4'h4: begin
              alu_b_q <= op_w.xkk.kk;
              skip_q  <= 1'b1;
              ne_q    <= op_w.xyn.op[2];
            end
            4'h5, 4'h9: begin
              skip_q <= 1'b1;
              ne_q   <= op_w.xyn.op[3];
              if (op_w.xyn.n != 4'h0) state <= SEQ_HALT;
            end
            4'h6: alu_b_q <= op_w.xkk.kk;
            4'h7: begin
              alu_op_q <= ALU_ADD;  // VF untouched
              alu_b_q  <= op_w.xkk.kk;
            end
            4'h8: begin
              flag_q <= (op_w.xyn.n != 4'h0);
              case (op_w.xyn.n)
                4'h0: alu_op_q <= ALU_PASS;
                4'h1: alu_op_q <= ALU_OR;
                4'h2: alu_op_q <= ALU_AND;
                4'h3: alu_op_q <= ALU_XOR;
                4'h4: alu_op_q <= ALU_ADD;
                4'h5: alu_op_q <= ALU_SUB;
                4'h6: alu_op_q <= ALU_SHR;
                4'h7: begin
                  alu_op_q <= ALU_SUB;  // vy - vx
                  alu_a_q  <= vy_i;
                  alu_b_q  <= vx_i;
                end
                4'hE: alu_op_q <= ALU_SHL;
                default: state <= SEQ_HALT;
              endcase
            end
            4'hA: begin
              use_alu_q <= 1'b0;
              to_i_q    <= 1'b1;
            end
            4'hF: begin
              case (op_w.xkk.kk)
                8'h1E: begin
                  alu_op_q <= ALU_ADD_INDEX;
                  to_i_q   <= 1'b1;
                end
                8'h33, 8'h55: begin
                  use_alu_q <= 1'b0;
                  use_st_q  <= 1'b1;
                  kind_q    <= op_w.xkk.kk[6] ? STORE_REGS : STORE_BCD;
                end
                default: state <= SEQ_HALT;
              endcase
            end
            default: state <= SEQ_HALT;
          endcase
        end
        SEQ_EXEC: begin
          if (use_st_q) state <= SEQ_WAIT_STORE;
          else if (use_alu_q) state <= SEQ_WAIT_ALU;
          else state <= SEQ_FETCH_HI;
        end
        SEQ_WAIT_ALU: if (alu_done_i) state <= SEQ_FETCH_HI;
        SEQ_WAIT_STORE: if (st_done_i) state <= SEQ_FETCH_HI;
        default: state <= SEQ_HALT;  // stuck until reset
      endcase
    end
  end

  // commit and start strobes
  always_comb begin
    pc_cmd_o    = PC_HOLD;
    reg_we_o    = 1'b0;
    flag_we_o   = 1'b0;
    i_we_o      = 1'b0;
    i_wdata_o   = i_reg_i;
    alu_start_o = 1'b0;
    st_start_o  = 1'b0;
    case (state)
      SEQ_EXEC: begin
        alu_start_o = use_alu_q;
        st_start_o  = use_st_q;
        if (!use_alu_q && !use_st_q) begin
          pc_cmd_o  = pc_cmd_q;
          i_we_o    = to_i_q;
          i_wdata_o = op_q.nnn.addr;
        end
      end
      SEQ_WAIT_ALU: begin
        if (alu_done_i) begin
          pc_cmd_o = PC_STEP;
          if (skip_q) begin
            if (alu_zero_i != ne_q) pc_cmd_o = PC_SKIP;
          end else if (to_i_q) begin
            i_we_o    = 1'b1;
            i_wdata_o = alu_result_i;
          end else begin
            reg_we_o  = 1'b1;
            flag_we_o = flag_q;
          end
        end
      end
      SEQ_WAIT_STORE: if (st_done_i) pc_cmd_o = PC_STEP;
      default: ;
    endcase
  end

endmodule

//--- logic/chip8_store_engine.sv
`timescale 1ns/1ps

module chip8_store_engine (
  input  logic                         clk_in,
  input  logic                         arst_n_i,
  input  logic                         start_i,
  input  chip8_pkg::chip8_store_kind_e kind_i,
  input  chip8_pkg::chip8_reg_idx_t    last_idx_i,
  input  chip8_pkg::chip8_addr_t       base_i,
  output chip8_pkg::chip8_reg_idx_t    rs_idx_o,
  input  chip8_pkg::chip8_byte_t       vs_i,
  output chip8_pkg::chip8_addr_t       wr_addr_o,
  output chip8_pkg::chip8_byte_t       wr_data_o,
  output logic                         wr_en_o,
  output logic                         done_o
);

  import chip8_pkg::*;

  chip8_store_kind_e kind_q;
  logic              active_q;
  chip8_reg_idx_t    cnt_q;
  chip8_reg_idx_t    last_w;
  chip8_byte_t       digit_w;

  // bcd always writes three digits
  assign last_w   = (kind_q == STORE_BCD) ? chip8_reg_idx_t'(2) : last_idx_i;
  assign rs_idx_o = (kind_q == STORE_BCD) ? last_idx_i : cnt_q;

  always_comb begin
    case (cnt_q)
      4'd0:    digit_w = vs_i / 8'd100;
      4'd1:    digit_w = vs_i / 8'd10 % 8'd10;
      default: digit_w = vs_i % 8'd10;
    endcase
  end

  assign wr_en_o   = active_q;
  assign done_o    = active_q && (cnt_q == last_w);
  assign wr_addr_o = base_i + chip8_addr_t'(cnt_q);
  assign wr_data_o = (kind_q == STORE_BCD) ? digit_w : vs_i;

  always_ff @(posedge clk_in or negedge arst_n_i) begin
    if (!arst_n_i) begin
      kind_q   <= STORE_BCD;
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (start_i) begin
      kind_q   <= kind_i;
      active_q <= 1'b1;
      cnt_q    <= '0;
    end else if (active_q) begin
      if (done_o) active_q <= 1'b0;
      else cnt_q <= cnt_q + 1'b1;  // one byte per cycle
    end
  end

endmodule

//--- tests/chip8_tb_model.svh
`ifndef CHIP8_TB_MODEL_SVH
`define CHIP8_TB_MODEL_SVH

// instruction level reference that walks mem from the reset pc and queues every store
task automatic run_model(output chip8_addr_t halt_pc);
  chip8_byte_t v [16];
  chip8_addr_t stack [16];
  chip8_addr_t pc;
  chip8_addr_t cur;
  chip8_addr_t i_reg;
  logic [3:0]  sp;
  logic [15:0] w;
  logic [3:0]  x;
  logic [3:0]  y;
  chip8_byte_t kk;
  chip8_byte_t res;
  int          tot;
  int          val;
  logic        fl;
  logic        stop;
  int          steps;
  foreach (v[k]) v[k] = '0;
  pc      = CHIP8_PROG_START;
  i_reg   = '0;
  sp      = '0;
  stop    = 1'b0;
  steps   = 0;
  halt_pc = pc;
  while (!stop) begin
    cur = pc;
    w   = {mem[cur], mem[cur + 12'd1]};
    x   = w[11:8];
    y   = w[7:4];
    kk  = w[7:0];
    pc  = cur + 12'd2;
    case (w[15:12])
      4'h0: begin
        if (w[11:0] == 12'h0EE) begin
          sp = sp - 4'd1;
          pc = stack[sp] + 12'd2;
        end else stop = 1'b1;
      end
      4'h1: pc = w[11:0];
      4'h2: begin
        stack[sp] = cur;
        sp        = sp + 4'd1;
        pc        = w[11:0];
      end
      4'h3: if (v[x] == kk) pc = pc + 12'd2;
      4'h4: if (v[x] != kk) pc = pc + 12'd2;
      4'h5: begin
        if (w[3:0] != 4'h0) stop = 1'b1;
        else if (v[x] == v[y]) pc = pc + 12'd2;
      end
      4'h9: begin
        if (w[3:0] != 4'h0) stop = 1'b1;
        else if (v[x] != v[y]) pc = pc + 12'd2;
      end
      4'h6: v[x] = kk;
      4'h7: v[x] = v[x] + kk;  // no carry out to VF
      4'h8: begin
        fl  = 1'b0;
        res = '0;
        case (w[3:0])
          4'h0: res = v[y];
          4'h1: res = v[x] | v[y];
          4'h2: res = v[x] & v[y];
          4'h3: res = v[x] ^ v[y];
          4'h4: begin
            tot = int'(v[x]) + int'(v[y]);
            res = 8'(tot);
            fl  = (tot > 255);
          end
          4'h5: begin
            tot = int'(v[x]) - int'(v[y]);
            res = 8'(tot);
            fl  = (tot >= 0);
          end
          4'h6: begin
            res = v[x] >> 1;
            fl  = v[x][0];
          end
          4'h7: begin
            tot = int'(v[y]) - int'(v[x]);
            res = 8'(tot);
            fl  = (tot >= 0);
          end
          4'hE: begin
            res = v[x] << 1;
            fl  = v[x][7];
          end
          default: stop = 1'b1;
        endcase
        if (!stop) begin
          v[x] = res;
          if (w[3:0] != 4'h0) v[15] = {7'd0, fl};  // flag lands last
        end
      end
      4'hA: i_reg = w[11:0];
      4'hF: begin
        case (kk)
          8'h1E: i_reg = i_reg + {4'h0, v[x]};
          8'h33: begin
            val = v[x];
            exp_addr.push_back(i_reg);
            exp_data.push_back(8'(val / 100));
            exp_addr.push_back(i_reg + 12'd1);
            exp_data.push_back(8'((val % 100) / 10));
            exp_addr.push_back(i_reg + 12'd2);
            exp_data.push_back(8'(val % 10));
          end
          8'h55: begin
            for (int k = 0; k <= x; k++) begin
              exp_addr.push_back(i_reg + 12'(k));
              exp_data.push_back(v[k]);
            end
          end
          default: stop = 1'b1;
        endcase
      end
      default: stop = 1'b1;
    endcase
    if (stop) halt_pc = cur;
    steps++;
    if (steps > 4000) begin
      $display("%s: reference model never reached a halting opcode", test_name);
      abort_run();
    end
  end
endtask

`endif

//--- tests/chip8_tb.sv
`timescale 1ns/1ps

module chip8_tb;

  import chip8_pkg::*;

  logic        clk_in    = 1'b0;
  logic        arst_n_i  = 1'b0;
  chip8_byte_t rd_data_i = '0;
  chip8_addr_t rd_addr_o;
  chip8_addr_t wr_addr_o;
  chip8_byte_t wr_data_o;
  logic        wr_en_o;
  logic        halt_o;

  chip8_byte_t mem [4096];
  chip8_addr_t exp_addr [$];
  chip8_byte_t exp_data [$];
  chip8_addr_t wp;                   // generator write pointer
  int          n_instr     = 0;
  int          cycles      = 0;
  int          cycle_limit = 100;    // grows with each program
  logic [31:0] rng         = 32'h44a6;
  string       test_name   = "none";

  chip8_cpu u_dut (
    .clk_in   (clk_in),
    .arst_n_i (arst_n_i),
    .rd_data_i(rd_data_i),
    .rd_addr_o(rd_addr_o),
    .wr_addr_o(wr_addr_o),
    .wr_data_o(wr_data_o),
    .wr_en_o  (wr_en_o),
    .halt_o   (halt_o)
  );

  initial begin
    forever #20 clk_in = ~clk_in;
  end

  // byte memory with read data one cycle after the address
  always @(posedge clk_in) begin
    rd_data_i <= mem[rd_addr_o];
    if (wr_en_o) mem[wr_addr_o] = wr_data_o;
  end

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_write(input string name, input chip8_addr_t exp_a,
                             input chip8_byte_t exp_d, input chip8_addr_t act_a,
                             input chip8_byte_t act_d);
    if (exp_a !== act_a || exp_d !== act_d) begin
      $display("CHECK FAILED %s write: expected %h at %h, actual %h at %h",
               name, exp_d, exp_a, act_d, act_a);
      abort_run();
    end
  endtask

  task automatic check_halt_addr(input string name, input chip8_addr_t exp_a,
                                 input chip8_addr_t act_a);
    if (exp_a !== act_a) begin
      $display("CHECK FAILED %s halt address: expected %h, actual %h", name, exp_a, act_a);
      abort_run();
    end
  endtask

  always @(posedge clk_in) begin
    if (arst_n_i && wr_en_o) begin
      if (exp_addr.size() == 0) begin
        $display("%s: unexpected write of %h to %h", test_name, wr_data_o, wr_addr_o);
        abort_run();
      end else begin
        check_write(test_name, exp_addr[0], exp_data[0], wr_addr_o, wr_data_o);
        exp_addr.delete(0);
        exp_data.delete(0);
      end
    end
  end

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout in test %s, core did not halt within %0d cycles", test_name, cycles);
      abort_run();
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] r;
    r = s ^ (s << 13);
    r = r ^ (r >> 17);
    r = r ^ (r << 5);
    return r;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int unsigned rnd_below(input int unsigned n);
    return rand_word() % n;
  endfunction

  task automatic emit(input logic [15:0] word);
    mem[wp]         = word[15:8];
    mem[wp + 12'd1] = word[7:0];
    wp              = wp + 12'd2;
    n_instr         = n_instr + 1;
  endtask

  task automatic fill_memory();
    for (int a = 0; a < 4096; a++) begin
      mem[a] = 8'(a) ^ 8'(a >> 4);
    end
  endtask

  task automatic end_program();
    emit({4'hA, 12'h800 + 12'(rnd_below(12'h600))});
    emit(16'hFF55);  // dump V0..VF
    emit(16'hFFFF);
  endtask

  `include "chip8_tb_model.svh"

  task automatic begin_test(input string name);
    test_name = name;
    @(posedge clk_in);
    arst_n_i <= 1'b0;
    @(negedge clk_in);
    fill_memory();
    wp      = CHIP8_PROG_START;
    n_instr = 0;
  endtask

  task automatic run_program();
    chip8_addr_t halt_pc;
    run_model(halt_pc);
    cycle_limit = cycle_limit + 40 * n_instr;
    repeat (5) @(posedge clk_in);
    arst_n_i <= 1'b1;
    do begin
      @(posedge clk_in);
    end while (!halt_o);
    if (exp_addr.size() != 0) begin
      $display("%s: core halted with %0d expected writes missing", test_name, exp_addr.size());
      abort_run();
    end
    check_halt_addr(test_name, halt_pc + 12'd1, rd_addr_o);
    repeat (20) @(posedge clk_in);  // halted core must stay quiet
    check_halt_addr(test_name, halt_pc + 12'd1, rd_addr_o);
    if (!halt_o) begin
      $display("%s: halt_o dropped after the core halted", test_name);
      abort_run();
    end
  endtask

  task automatic gen_alu();
    logic [3:0]  x;
    logic [3:0]  y;
    logic [3:0]  n;
    int unsigned pick;
    for (int k = 0; k < 16; k++) begin
      emit({4'h6, 4'(k), 8'(rand_word())});
    end
    repeat (24) begin
      x    = 4'(rand_word());
      y    = 4'(rand_word());
      pick = rnd_below(11);
      n    = (pick == 10) ? 4'hE : 4'(pick - 2);
      if (pick == 0) emit({4'h6, x, 8'(rand_word())});
      else if (pick == 1) emit({4'h7, x, 8'(rand_word())});
      else emit({4'h8, x, y, n});
    end
    emit({4'h8, 4'hF, 4'(rnd_below(15)), 4'h4});  // sum and carry both aim at VF
    end_program();
  endtask

  task automatic gen_skip();
    logic [3:0]  x;
    logic [3:0]  y;
    chip8_byte_t kk;
    // small values so equal compares are common
    for (int k = 0; k < 8; k++) begin
      emit({4'h6, 4'(k), 8'(rnd_below(4))});
    end
    for (int k = 0; k < 16; k++) begin
      x  = {1'b0, 3'(rand_word())};
      y  = {1'b0, 3'(rand_word())};
      kk = 8'(rnd_below(4));
      case (rnd_below(4))
        0: emit({4'h3, x, kk});
        1: emit({4'h4, x, kk});
        2: emit({4'h5, x, y, 4'h0});
        default: emit({4'h9, x, y, 4'h0});
      endcase
      emit({4'h6, 1'b1, 3'(rand_word()), 8'(k + 1)});  // marker
    end
    end_program();
  endtask

  task automatic gen_calls();
    int depth;
    depth = 1 + rnd_below(8);
    emit({4'h6, 4'(rand_word()), 8'h11});
    emit(16'h2400);
    emit({4'h1, wp + 12'd4});  // hop over the trap
    emit(16'h0000);            // halts if ever reached
    emit({4'h6, 4'(rand_word()), 8'h22});
    end_program();
    for (int k = 0; k < depth; k++) begin
      wp = 12'h400 + 12'(16 * k);
      emit({4'h6, 4'(k), 8'(8'h40 + k)});
      if (k < depth - 1) emit({4'h2, 12'h400 + 12'(16 * (k + 1))});
      emit({4'h6, 4'(k + 8), 8'(8'h80 + k)});
      emit(16'h00EE);
    end
  endtask

  task automatic gen_bcd();
    logic [3:0] x;
    logic [3:0] y;
    repeat (5) begin
      x = 4'(rand_word());
      y = 4'(rand_word());
      emit({4'hA, 12'h800 + 12'(rnd_below(12'h500))});
      emit({4'h6, x, 8'(rand_word())});
      emit({4'h6, y, 8'(rand_word())});
      emit({4'hF, y, 8'h1E});
      emit({4'hF, x, 8'h33});
    end
    end_program();
  endtask

  task automatic gen_halt();
    repeat (4) emit({4'h6, 4'(rand_word()), 8'(rand_word())});
    emit({4'h7, 4'(rand_word()), 8'(rand_word())});
    end_program();
  endtask

  initial begin
    begin_test("alu_mix");
    gen_alu();
    run_program();
    begin_test("skips");
    gen_skip();
    run_program();
    begin_test("call_ret");
    gen_calls();
    run_program();
    begin_test("index_bcd");
    gen_bcd();
    run_program();
    begin_test("halt");
    gen_halt();
    run_program();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
